// ==== hw/chan_pkg.sv ====
package chan_pkg;

	////////////////////
	// widths
	localparam int SAMPLE_W          = 12;  // adc sample
	localparam int LANE_W            = 16;  // one lane of a burst
	localparam int SAMPLES_PER_BURST = 8;
	localparam int WORD_W            = LANE_W * SAMPLES_PER_BURST;  // store word, 128 bits
	localparam int BEAT_W            = 32;  // stream beat
	localparam int BURST_CNT_W       = 21;
	localparam int FILL_NUM_W        = 24;
	localparam int TAG_W             = 16;
	localparam int CH_ADDR_W         = 3;

	////////////////////
	// enums
	typedef enum logic [1:0] {
		FILL_NONE  = 2'b00,  // not armed
		FILL_MUON  = 2'b01,
		FILL_LASER = 2'b10,
		FILL_PED   = 2'b11
	} fill_type_e;  // {acq_enable1, acq_enable0}

	typedef enum logic [1:0] {
		ACQ_IDLE,
		ACQ_HEADER,  // header word going into the store
		ACQ_FILL,    // collecting bursts
		ACQ_DONE     // last burst written, commit next
	} acq_state_e;

	typedef enum logic [2:0] {
		REG_CHANNEL_TAG,
		REG_MUON_BURSTS,
		REG_LASER_BURSTS,
		REG_PED_BURSTS,
		REG_INIT_FILL
	} reg_op_e;

	////////////////////
	// structs
	typedef struct packed {
		logic [TAG_W-1:0]       channel_tag;   // goes into every header
		logic [BURST_CNT_W-1:0] muon_bursts;   // bursts per muon fill
		logic [BURST_CNT_W-1:0] laser_bursts;  // bursts per laser fill
		logic [BURST_CNT_W-1:0] ped_bursts;    // bursts per pedestal fill
	} chan_cfg_t;

	typedef struct packed {
		logic [FILL_NUM_W-1:0]  fill_num;
		fill_type_e             fill_type;
		logic [CH_ADDR_W-1:0]   ch_addr;
		logic [TAG_W-1:0]       channel_tag;
		logic [BURST_CNT_W-1:0] num_bursts;
		logic [WORD_W-FILL_NUM_W-2-CH_ADDR_W-TAG_W-BURST_CNT_W-1:0] pad;  // 62 zero bits
	} fill_hdr_t;

	typedef struct packed {
		logic [LANE_W-SAMPLE_W-2:0] pad;  // three zero bits
		logic                       ovr;  // over-range
		logic [SAMPLE_W-1:0]        data;
	} adc_sample_t;

	typedef struct packed {
		logic                   we;
		logic [BURST_CNT_W-1:0] addr;  // word address, 0 is the header
		logic [WORD_W-1:0]      data;
	} store_wr_t;

endpackage

// ==== hw/chan_regs.sv ====
`timescale 1ns/100ps

module chan_regs import chan_pkg::*; #(
	parameter int MEM_DEPTH = 64
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  reg_wr,         // one cycle write strobe
	input  reg_op_e               reg_op,
	input  logic [31:0]           reg_wdata,
	output chan_cfg_t             cfg,
	output logic                  init_fill_wr,   // load strobe for the fill counter
	output logic [FILL_NUM_W-1:0] init_fill_num
);

	localparam logic [BURST_CNT_W-1:0] MAX_BURSTS = BURST_CNT_W'(MEM_DEPTH - 1);  // header needs word 0

	logic [BURST_CNT_W-1:0] wr_bursts;  // clamped burst count

	assign wr_bursts = (reg_wdata > 32'(MEM_DEPTH - 1)) ? MAX_BURSTS
	                                                    : reg_wdata[BURST_CNT_W-1:0];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cfg          <= '0;    // zero counts give header-only fills
			init_fill_wr <= 1'b0;
		end else begin
			init_fill_wr <= 1'b0;  // pulse
			if (reg_wr) begin
				case (reg_op)
					REG_CHANNEL_TAG:  cfg.channel_tag  <= reg_wdata[TAG_W-1:0];
					REG_MUON_BURSTS:  cfg.muon_bursts  <= wr_bursts;
					REG_LASER_BURSTS: cfg.laser_bursts <= wr_bursts;
					REG_PED_BURSTS:   cfg.ped_bursts   <= wr_bursts;
					REG_INIT_FILL:    init_fill_wr     <= 1'b1;
					default:          ;                // unknown opcode ignored
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reg_wr && reg_op == REG_INIT_FILL)
			init_fill_num <= reg_wdata[FILL_NUM_W-1:0];  // low 24 bits
	end

endmodule

// ==== hw/acq_ctrl.sv ====
`timescale 1ns/100ps

module acq_ctrl import chan_pkg::*; #(
	parameter int MEM_DEPTH = 64
) (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic                         acq_trig,
	input  logic                         acq_enable0,
	input  logic                         acq_enable1,
	input  logic                         acq_reset,
	input  chan_cfg_t                    cfg,
	input  logic [CH_ADDR_W-1:0]         ch_addr,
	input  logic                         init_fill_wr,
	input  logic [FILL_NUM_W-1:0]        init_fill_num,
	input  logic                         fill_ready,      // store still holds a fill
	input  logic                         burst_valid,
	input  logic [WORD_W-1:0]            burst_word,
	output logic                         fill_en,         // packer captures while high
	output store_wr_t                    store_wr,
	output logic                         fill_commit,
	output logic [$clog2(MEM_DEPTH)-1:0] fill_last_addr,
	output logic                         acq_done
);

	localparam int AW = $clog2(MEM_DEPTH);

	acq_state_e             state;
	fill_type_e             fill_type;
	logic [BURST_CNT_W-1:0] sel_bursts;    // count for the armed fill type
	logic [BURST_CNT_W-1:0] num_bursts_q;  // count of the running fill
	logic [BURST_CNT_W+2:0] samples_left;  // eight per burst
	logic [AW-1:0]          burst_addr;    // next store address for a burst
	logic [FILL_NUM_W-1:0]  fill_num;
	fill_hdr_t              hdr;
	logic                   accept;

	assign fill_type = fill_type_e'({acq_enable1, acq_enable0});

	always_comb begin
		case (fill_type)
			FILL_MUON:  sel_bursts = cfg.muon_bursts;
			FILL_LASER: sel_bursts = cfg.laser_bursts;
			FILL_PED:   sel_bursts = cfg.ped_bursts;
			default:    sel_bursts = '0;
		endcase
	end

	// commit still in flight counts as a full store
	assign accept = acq_trig && (state == ACQ_IDLE) && (fill_type != FILL_NONE)
	                && !fill_ready && !fill_commit;

	always_comb begin
		hdr             = '0;
		hdr.fill_num    = fill_num;
		hdr.fill_type   = fill_type;
		hdr.ch_addr     = ch_addr;
		hdr.channel_tag = cfg.channel_tag;
		hdr.num_bursts  = sel_bursts;
	end

	assign fill_last_addr = num_bursts_q[AW-1:0];  // clamped below MEM_DEPTH

	////////////////////
	// fill sequencing
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state        <= ACQ_IDLE;
			fill_en      <= 1'b0;
			store_wr     <= '0;
			fill_commit  <= 1'b0;
			acq_done     <= 1'b0;
			samples_left <= '0;
			burst_addr   <= '0;
			num_bursts_q <= '0;
		end else begin
			store_wr.we <= 1'b0;  // strobes default low
			fill_commit <= 1'b0;
			acq_done    <= 1'b0;
			if (acq_reset) begin
				state   <= ACQ_IDLE;
				fill_en <= 1'b0;
			end else begin
				if (fill_en) begin
					samples_left <= samples_left - 1'b1;
					if (samples_left == 1)
						fill_en <= 1'b0;  // last sample window
				end
				case (state)
					ACQ_IDLE: begin
						if (accept) begin
							state        <= ACQ_HEADER;
							num_bursts_q <= sel_bursts;
							samples_left <= {sel_bursts, 3'b000};
							fill_en      <= (sel_bursts != '0);
							burst_addr   <= AW'(1);
							store_wr     <= '{we: 1'b1, addr: '0, data: hdr};  // header at 0
						end
					end
					ACQ_HEADER: state <= (num_bursts_q == '0) ? ACQ_DONE : ACQ_FILL;
					ACQ_FILL: begin
						if (burst_valid) begin
							store_wr   <= '{we: 1'b1, addr: BURST_CNT_W'(burst_addr),
							                data: burst_word};
							burst_addr <= burst_addr + 1'b1;
							if (burst_addr == num_bursts_q[AW-1:0])
								state <= ACQ_DONE;
						end
					end
					ACQ_DONE: begin
						acq_done    <= 1'b1;
						fill_commit <= 1'b1;  // store now holds the fill
						state       <= ACQ_IDLE;
					end
					default: state <= ACQ_IDLE;
				endcase
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			fill_num <= '0;
		else if (init_fill_wr)
			fill_num <= init_fill_num;
		else if (fill_commit)
			fill_num <= fill_num + 1'b1;  // next fill
	end

endmodule

// ==== hw/burst_packer.sv ====
`timescale 1ns/100ps

module burst_packer import chan_pkg::*; (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                acq_reset,
	input  logic                fill_en,      // capture window from acq_ctrl
	input  logic [SAMPLE_W-1:0] adc_data,
	input  logic                adc_ovr,
	output logic                burst_valid,  // burst_word complete this cycle
	output logic [WORD_W-1:0]   burst_word
);

	localparam int CNT_W = $clog2(SAMPLES_PER_BURST);

	adc_sample_t      lane;
	logic [CNT_W-1:0] sample_cnt;  // wraps every burst

	assign lane = '{pad: '0, ovr: adc_ovr, data: adc_data};

	// first sample ends up in the top lane
	always_ff @(posedge clk) begin
		if (fill_en)
			burst_word <= {burst_word[WORD_W-LANE_W-1:0], lane};
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sample_cnt  <= '0;
			burst_valid <= 1'b0;
		end else if (acq_reset) begin
			sample_cnt  <= '0;
			burst_valid <= 1'b0;
		end else begin
			burst_valid <= fill_en && (sample_cnt == CNT_W'(SAMPLES_PER_BURST - 1));
			if (fill_en)
				sample_cnt <= sample_cnt + 1'b1;
		end
	end

endmodule

// ==== hw/fill_store.sv ====
`timescale 1ns/100ps

module fill_store import chan_pkg::*; #(
	parameter int MEM_DEPTH = 64
) (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic                         acq_reset,     // drops a stored fill
	input  store_wr_t                    store_wr,
	input  logic                         fill_commit,   // fill complete
	input  logic                         fill_release,  // fill read out
	input  logic                         rd_en,
	input  logic [$clog2(MEM_DEPTH)-1:0] rd_addr,
	output logic [WORD_W-1:0]            rd_word,       // one cycle after rd_en
	output logic                         fill_ready
);

	localparam int AW = $clog2(MEM_DEPTH);

	logic [WORD_W-1:0] mem [MEM_DEPTH];  // header at 0, bursts from 1

	always_ff @(posedge clk) begin
		if (store_wr.we)
			mem[store_wr.addr[AW-1:0]] <= store_wr.data;
		if (rd_en)
			rd_word <= mem[rd_addr];  // holds between reads
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			fill_ready <= 1'b0;
		else if (acq_reset || fill_release)
			fill_ready <= 1'b0;
		else if (fill_commit)
			fill_ready <= 1'b1;
	end

endmodule

// ==== hw/readout_engine.sv ====
`timescale 1ns/100ps

module readout_engine import chan_pkg::*; #(
	parameter int MEM_DEPTH = 64
) (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic                         fill_ready,
	input  logic [$clog2(MEM_DEPTH)-1:0] fill_last_addr,
	input  logic [WORD_W-1:0]            rd_word,
	input  logic                         tx_ready,
	input  logic                         readout_pause,  // no new word while high
	output logic                         rd_en,
	output logic [$clog2(MEM_DEPTH)-1:0] rd_addr,
	output logic [BEAT_W-1:0]            tx_data,
	output logic                         tx_valid,
	output logic                         tx_last,
	output logic                         fill_release
);

	localparam int AW         = $clog2(MEM_DEPTH);
	localparam int BEATS      = WORD_W / BEAT_W;  // four beats per word
	localparam int BEAT_CNT_W = $clog2(BEATS);

	typedef enum logic [1:0] {
		RD_IDLE,   // between words
		RD_FETCH,  // store read in flight
		RD_SEND    // beats going out
	} rd_state_e;

	rd_state_e             state;
	logic [AW-1:0]         word_addr;
	logic [BEAT_CNT_W-1:0] beat;
	logic [WORD_W-1:0]     word_q;  // shifts up one beat per transfer
	logic                  beat_acc;

	assign rd_en        = (state == RD_IDLE) && fill_ready && !readout_pause;
	assign rd_addr      = word_addr;
	assign tx_data      = word_q[WORD_W-1 -: BEAT_W];  // msb beat first
	assign beat_acc     = tx_valid && tx_ready;
	assign tx_last      = tx_valid && (beat == BEAT_CNT_W'(BEATS - 1))
	                      && (word_addr == fill_last_addr);
	assign fill_release = beat_acc && tx_last;

	always_ff @(posedge clk) begin
		if (state == RD_FETCH)
			word_q <= rd_word;
		else if (beat_acc)
			word_q <= word_q << BEAT_W;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state     <= RD_IDLE;
			word_addr <= '0;
			beat      <= '0;
			tx_valid  <= 1'b0;
		end else begin
			case (state)
				RD_IDLE: begin
					if (rd_en)
						state <= RD_FETCH;
					else if (!fill_ready)
						word_addr <= '0;  // fill dropped, restart at header
				end
				RD_FETCH: begin
					tx_valid <= 1'b1;
					beat     <= '0;
					state    <= RD_SEND;
				end
				RD_SEND: begin
					if (beat_acc) begin
						beat <= beat + 1'b1;
						if (beat == BEAT_CNT_W'(BEATS - 1)) begin
							tx_valid  <= 1'b0;
							state     <= RD_IDLE;
							word_addr <= tx_last ? '0 : word_addr + 1'b1;
						end
					end
				end
				default: state <= RD_IDLE;
			endcase
		end
	end

endmodule

// ==== hw/chan_top.sv ====
`timescale 1ns/100ps

module chan_top import chan_pkg::*; #(
	parameter int MEM_DEPTH = 64  // words in the fill store
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic [CH_ADDR_W-1:0] ch_addr,        // address jumpers
	input  logic                 acq_trig,       // start a fill
	input  logic                 acq_enable0,    // arming and fill type
	input  logic                 acq_enable1,
	input  logic                 acq_reset,      // abort acquisition
	output logic                 acq_done,       // fill stored
	input  logic [SAMPLE_W-1:0]  adc_data,
	input  logic                 adc_ovr,
	input  logic                 reg_wr,         // config write strobe
	input  reg_op_e              reg_op,
	input  logic [31:0]          reg_wdata,
	output logic [BEAT_W-1:0]    tx_data,        // readout stream
	output logic                 tx_valid,
	output logic                 tx_last,
	input  logic                 tx_ready,
	input  logic                 readout_pause   // hold off between words
);

	chan_cfg_t                      cfg;
	logic                           init_fill_wr;
	logic [FILL_NUM_W-1:0]          init_fill_num;
	logic                           fill_en;         // packer capture window
	logic                           burst_valid;
	logic [WORD_W-1:0]              burst_word;
	store_wr_t                      store_wr;
	logic                           fill_commit;
	logic                           fill_release;
	logic                           fill_ready;      // one fill sits in the store
	logic [$clog2(MEM_DEPTH)-1:0]   fill_last_addr;  // address of the last burst
	logic                           rd_en;
	logic [$clog2(MEM_DEPTH)-1:0]   rd_addr;
	logic [WORD_W-1:0]              rd_word;

	////////////////////
	// configuration and acquisition
	chan_regs #(.MEM_DEPTH(MEM_DEPTH)) i_chan_regs (
		.clk, .rst_n, .reg_wr, .reg_op, .reg_wdata,
		.cfg, .init_fill_wr, .init_fill_num
	);

	acq_ctrl #(.MEM_DEPTH(MEM_DEPTH)) i_acq_ctrl (
		.clk, .rst_n, .acq_trig, .acq_enable0, .acq_enable1, .acq_reset,
		.cfg, .ch_addr, .init_fill_wr, .init_fill_num, .fill_ready,
		.burst_valid, .burst_word,
		.fill_en, .store_wr, .fill_commit, .fill_last_addr, .acq_done
	);

	burst_packer i_burst_packer (
		.clk, .rst_n, .acq_reset, .fill_en, .adc_data, .adc_ovr,
		.burst_valid, .burst_word
	);

	////////////////////
	// storage and readout
	fill_store #(.MEM_DEPTH(MEM_DEPTH)) i_fill_store (
		.clk, .rst_n, .acq_reset, .store_wr, .fill_commit, .fill_release,
		.rd_en, .rd_addr, .rd_word, .fill_ready
	);

	readout_engine #(.MEM_DEPTH(MEM_DEPTH)) i_readout_engine (
		.clk, .rst_n, .fill_ready, .fill_last_addr, .rd_word, .tx_ready, .readout_pause,
		.rd_en, .rd_addr, .tx_data, .tx_valid, .tx_last, .fill_release
	);

endmodule

// ==== sim/chan_assertions.sv ====
`timescale 1ns/100ps

module chan_assertions import chan_pkg::*; (
	input logic              clk,
	input logic              rst_n,
	input logic              acq_done,
	input store_wr_t         store_wr,
	input logic              fill_ready,
	input logic              tx_valid,
	input logic              tx_ready,
	input logic              tx_last,
	input logic [BEAT_W-1:0] tx_data,
	input logic              readout_pause
);

	int        fail_cnt = 0;  // failed assertions so far
	fill_hdr_t hdr;
	logic      hdr_wr;        // header write one cycle after an accepted trigger
	int        since_trig;    // cycles since the accepted trigger
	int        want_done;     // expected acq_done latency

	assign hdr    = store_wr.data;
	assign hdr_wr = store_wr.we && store_wr.addr == '0;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			since_trig <= 0;
			want_done  <= 0;
		end else if (hdr_wr) begin
			since_trig <= 1;
			want_done  <= 32'(hdr.num_bursts) * SAMPLES_PER_BURST + 2;
		end else begin
			since_trig <= since_trig + 1;
		end
	end

	a_reset_quiet: assert property (@(posedge clk)
		!rst_n |-> !acq_done && !tx_valid && !tx_last && !fill_ready && !store_wr.we)
		else begin fail_cnt++; $error("outputs active during reset"); end

	a_tx_hold: assert property (@(posedge clk) disable iff (!rst_n)
		tx_valid && !tx_ready |=> tx_valid && $stable(tx_data))
		else begin fail_cnt++; $error("stream beat changed while stalled"); end

	a_release: assert property (@(posedge clk) disable iff (!rst_n)
		tx_valid && tx_ready && tx_last |=> !fill_ready)
		else begin fail_cnt++; $error("fill_ready still set after the last beat"); end

	a_done_latency: assert property (@(posedge clk) disable iff (!rst_n)
		acq_done |-> since_trig == want_done)
		else begin fail_cnt++; $error("acq_done latency wrong or without a trigger"); end

	a_store_free: assert property (@(posedge clk) disable iff (!rst_n)
		store_wr.we |-> !fill_ready)
		else begin fail_cnt++; $error("store written while it still held a fill"); end

	a_first_beat: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(fill_ready) && !readout_pause |-> ##2 tx_valid)
		else begin fail_cnt++; $error("first beat not two cycles after fill_ready"); end

endmodule

bind chan_top chan_assertions i_chan_assertions (
	.clk, .rst_n, .acq_done, .store_wr, .fill_ready,
	.tx_valid, .tx_ready, .tx_last, .tx_data, .readout_pause
);

// ==== sim/tb_chan_top.sv ====
`timescale 1ns/100ps

module tb_chan_top import chan_pkg::*; ();

	localparam int              MEM_DEPTH = 64;
	localparam logic [TAG_W-1:0] TAG      = 16'hA5C3;

	logic                 clk, rst_n, acq_trig, acq_enable0, acq_enable1, acq_reset, acq_done;
	logic [CH_ADDR_W-1:0] ch_addr;
	logic [SAMPLE_W-1:0]  adc_data;
	logic                 adc_ovr, reg_wr, tx_valid, tx_last, tx_ready, readout_pause;
	reg_op_e              reg_op;
	logic [31:0]          reg_wdata;
	logic [BEAT_W-1:0]    tx_data;

	int                    seed = 64443;
	int                    sample_idx;    // ramp position advancing every cycle
	int                    ready_mode;    // 0 always ready, 1 random, 2 held low
	bit                    pause_on;
	logic [BEAT_W-1:0]     exp_data[$];   // expected beats in stream order
	bit                    exp_last[$];
	int                    errors, done_cnt, fills_done, drain_limit;
	int                    bursts_cfg[4];  // effective count per fill type
	logic [FILL_NUM_W-1:0] exp_fill_num;
	string                 test_name;

	chan_top #(.MEM_DEPTH(MEM_DEPTH)) i_chan_top (.*);

	function automatic int fill_cycles(input int n);
		return n * 8 + 2 + (n + 1) * 4;  // capture, commit and four beats per word
	endfunction

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	////////////////////
	// free running stimulus
	always @(negedge clk) begin
		adc_data   <= sample_idx[SAMPLE_W-1:0];
		adc_ovr    <= (sample_idx % 7 == 0);  // every seventh sample over range
		sample_idx <= sample_idx + 1;
		case (ready_mode)
			0:       tx_ready <= 1'b1;
			1:       tx_ready <= ($random(seed) & 1) != 0;
			default: tx_ready <= 1'b0;
		endcase
		readout_pause <= pause_on && (($random(seed) & 15) == 0);  // short pulses
	end

	////////////////////
	// stream scoreboard
	task automatic check_beat(input logic [BEAT_W-1:0] exp, input bit last);
		assert (tx_data === exp) else begin
			errors++;
			$display("Fail %s tx_data expected %h actual %h", test_name, exp, tx_data);
		end
		assert (tx_last === last) else begin
			errors++;
			$display("Fail %s tx_last expected %b actual %b", test_name, last, tx_last);
		end
	endtask

	always @(posedge clk) begin
		if (acq_done)
			done_cnt++;
		if (tx_valid && tx_ready) begin
			assert (exp_data.size() != 0) else begin
				errors++;
				$display("%s: beat %h streamed while no fill was expected", test_name, tx_data);
			end
			if (exp_data.size() != 0)
				check_beat(exp_data.pop_front(), exp_last.pop_front());
		end
	end

	task automatic push_word(input logic [WORD_W-1:0] word, input bit last);
		for (int i = 0; i < WORD_W / BEAT_W; i++) begin
			exp_data.push_back(word[WORD_W-1-i*BEAT_W -: BEAT_W]);  // msb beat first
			exp_last.push_back(last && i == WORD_W / BEAT_W - 1);
		end
	endtask

	task automatic expect_fill(input fill_type_e ftype, input int n, input int first);
		logic [WORD_W-1:0] word;
		int                s;
		word = {exp_fill_num, ftype, ch_addr, TAG, BURST_CNT_W'(n), 62'b0};  // header
		push_word(word, n == 0);
		for (int b = 0; b < n; b++) begin
			word = '0;
			for (int k = 0; k < SAMPLES_PER_BURST; k++) begin
				s    = first + b * SAMPLES_PER_BURST + k;
				word = {word[WORD_W-LANE_W-1:0], 3'b000, (s % 7 == 0), s[SAMPLE_W-1:0]};
			end
			push_word(word, b == n - 1);
		end
	endtask

	////////////////////
	// stimulus tasks
	task automatic write_reg(input reg_op_e op, input logic [31:0] data);
		@(negedge clk);
		reg_wr    <= 1'b1;
		reg_op    <= op;
		reg_wdata <= data;
		@(negedge clk);
		reg_wr <= 1'b0;
	endtask

	task automatic set_bursts(input reg_op_e op, input fill_type_e ftype, input int value);
		write_reg(op, value);
		bursts_cfg[ftype] = (value > MEM_DEPTH - 1) ? MEM_DEPTH - 1 : value;  // header takes word 0
	endtask

	task automatic start_fill(input fill_type_e ftype, input string name);
		int n;
		int base;
		int cycles;
		test_name   = name;
		n           = bursts_cfg[ftype];
		drain_limit = 20 * fill_cycles(n);
		@(negedge clk);
		{acq_enable1, acq_enable0} <= ftype;
		acq_trig <= 1'b1;
		expect_fill(ftype, n, sample_idx + 1);  // capture starts one cycle after the trigger
		base = done_cnt;
		exp_fill_num++;
		fills_done++;
		@(negedge clk);
		acq_trig <= 1'b0;
		cycles = 0;
		while (done_cnt == base && cycles < n * 8 + 10) begin
			@(negedge clk);
			cycles++;
		end
		assert (done_cnt > base) else begin
			errors++;
			$display("%s: acq_done never came after the trigger", test_name);
		end
	endtask

	task automatic drain_fill();
		int cycles;
		cycles = 0;
		while (exp_data.size() != 0 && cycles < drain_limit) begin
			@(negedge clk);
			cycles++;
		end
		assert (exp_data.size() == 0) else begin
			errors++;
			$display("%s: stream stopped with %0d beats missing", test_name, exp_data.size());
		end
	endtask

	// trigger with neither enable set, or with the store still full
	task automatic trigger_ignored(input logic [1:0] enables, input string name);
		int base;
		test_name = name;
		base      = done_cnt;
		@(negedge clk);
		{acq_enable1, acq_enable0} <= enables;
		acq_trig <= 1'b1;
		@(negedge clk);
		acq_trig <= 1'b0;
		repeat (40) @(negedge clk);
		assert (done_cnt == base) else begin
			errors++;
			$display("%s: a trigger that should be ignored produced acq_done", test_name);
		end
	endtask

	////////////////////
	// test sequence
	initial begin
		rst_n         = 1'b0;
		ch_addr       = 3'd5;
		acq_trig      = 1'b0;
		acq_enable0   = 1'b0;
		acq_enable1   = 1'b0;
		acq_reset     = 1'b0;
		adc_data      = '0;
		adc_ovr       = 1'b0;
		reg_wr        = 1'b0;
		reg_op        = REG_CHANNEL_TAG;
		reg_wdata     = '0;
		tx_ready      = 1'b0;
		readout_pause = 1'b0;
		sample_idx    = 0;
		ready_mode    = 0;
		pause_on      = 1'b0;
		errors        = 0;
		done_cnt      = 0;
		fills_done    = 0;
		exp_fill_num  = '0;
		test_name     = "reset";
		repeat (3) @(negedge clk);
		rst_n <= 1'b1;
		assert (!acq_done && !tx_valid) else begin
			errors++;
			$display("reset: acq_done or tx_valid high after reset");
		end
		write_reg(REG_CHANNEL_TAG, TAG);
		set_bursts(REG_MUON_BURSTS, FILL_MUON, 3);
		set_bursts(REG_LASER_BURSTS, FILL_LASER, 2);
		set_bursts(REG_PED_BURSTS, FILL_PED, 0);  // header only
		write_reg(REG_INIT_FILL, 32'hFF00_0005);  // upper byte dropped
		exp_fill_num = 24'd5;
		start_fill(FILL_MUON, "muon_fill");
		drain_fill();
		trigger_ignored(2'b00, "unarmed_trigger");
		ready_mode <= 1;
		pause_on   <= 1'b1;
		start_fill(FILL_LASER, "laser_fill");
		drain_fill();
		start_fill(FILL_PED, "ped_fill");
		drain_fill();
		ready_mode <= 2;  // stall the stream so the store stays full
		start_fill(FILL_MUON, "blocked_fill");
		trigger_ignored(2'b01, "blocked_trigger");
		ready_mode <= 1;
		drain_fill();
		set_bursts(REG_MUON_BURSTS, FILL_MUON, 100);
		start_fill(FILL_MUON, "clamp_fill");
		drain_fill();
		repeat (10) @(negedge clk);
		assert (done_cnt == fills_done) else begin
			errors++;
			$display("Fail acq_done_count expected %0d actual %0d", fills_done, done_cnt);
		end
		$display("errors: scoreboard %0d, assertions %0d",
		         errors, i_chan_top.i_chan_assertions.fail_cnt);
		if (errors + i_chan_top.i_chan_assertions.fail_cnt == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

	// watchdog sized from the fills above plus the idle waits
	initial begin
		repeat (20 * (2 * fill_cycles(3) + fill_cycles(2) + fill_cycles(0)
		              + fill_cycles(MEM_DEPTH - 1)) + 400)
			@(posedge clk);
		$display("watchdog expired before the test sequence finished");
		$display("Simulation FAILED");
		$finish;
	end

endmodule

// ==== flist.f ====
hw/chan_pkg.sv
hw/chan_regs.sv
hw/acq_ctrl.sv
hw/burst_packer.sv
hw/fill_store.sv
hw/readout_engine.sv
hw/chan_top.sv
sim/chan_assertions.sv
sim/tb_chan_top.sv

// ==== Bender.yml ====
package:
  name: chan_readout

sources:
  - files:
      - hw/chan_pkg.sv
      - hw/chan_regs.sv
      - hw/acq_ctrl.sv
      - hw/burst_packer.sv
      - hw/fill_store.sv
      - hw/readout_engine.sv
      - hw/chan_top.sv
  - target: test
    files:
      - sim/chan_assertions.sv
      - sim/tb_chan_top.sv
